// File: common/seq_consts.svh
`ifndef SEQ_CONSTS_SVH
`define SEQ_CONSTS_SVH

// ====================
// instruction geometry
// ====================
`define WORD_W 32
`define LINE_WORDS 16
`define PC_W 16

// program memory depth in lines, as log2
`define LOG2_PROGRAM_SIZE 8

// operation classes, prefetch through copy
`define NUM_OPS 7

// pc value that ends a run
`define PC_HALT 16'hFFFF

// ====================
// index step codes
// ====================
`define IDX_HOLD 32'hEFFFFFFF
`define IDX_INC 32'h0FFFFFFF
`define IDX_DEC 32'h01FFFFFF

`endif

// File: common/seq_pkg.sv
`include "seq_consts.svh"

package seq_pkg;

    typedef logic [`WORD_W-1:0] word_t;

    // 512-bit line seen as 16 words
    // w15 control, w14 targets, w13 predicate, w10..12 scales
    // w3 base offset, w4 length, w0..2 index steps
    typedef word_t [`LINE_WORDS-1:0] line_t;

    typedef logic [`PC_W-1:0] pc_t;

    typedef enum logic [2:0]
    {
        MACH_IDLE,
        MACH_FETCH,
        MACH_DECODE,
        MACH_EXECUTE,
        MACH_DONE
    } mach_state_t;

    typedef enum logic
    {
        LOAD_IDLE,
        LOAD_RECEIVE
    } load_state_t;

    // control bits 7..4
    typedef enum logic [3:0]
    {
        OP_NONE      = 4'd0,
        OP_PREFETCH  = 4'd1,
        OP_LOAD      = 4'd2,
        OP_WRITEBACK = 4'd3,
        OP_DOT       = 4'd4,
        OP_MODIFY    = 4'd5,
        OP_UPDATE    = 4'd6,
        OP_COPY      = 4'd7
    } op_class_t;

    // control bits 3..0
    typedef enum logic [3:0]
    {
        BR_NEXT    = 4'd0,
        BR_ON_IDX0 = 4'd1,
        BR_ON_IDX1 = 4'd2,
        BR_ON_IDX2 = 4'd3
    } branch_t;

endpackage

// File: loader/program_loader.sv
module program_loader
(
    input  logic            clk,
    input  logic            reset,
    input  logic            start,
    input  seq_pkg::pc_t    program_length,
    input  logic            line_valid,
    input  seq_pkg::line_t  line_data,
    output logic            we,
    output seq_pkg::pc_t    waddr,
    output seq_pkg::line_t  wdata,
    output logic            program_ready
);

    seq_pkg::load_state_t state;
    seq_pkg::pc_t prog_len;
    seq_pkg::pc_t line_count;
    logic last_line;

    // each strobe lands in memory on the next edge
    assign we = line_valid && (state == seq_pkg::LOAD_RECEIVE);
    assign waddr = line_count;
    assign wdata = line_data;

    assign last_line = (line_count == seq_pkg::pc_t'(prog_len - 1'b1));

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= seq_pkg::LOAD_IDLE;
            line_count <= '0;
            program_ready <= 1'b0;
        end
        else
        begin
            program_ready <= 1'b0;
            case (state)
                seq_pkg::LOAD_IDLE:
                begin
                    if (start)
                    begin
                        prog_len <= program_length;
                        line_count <= '0;
                        state <= seq_pkg::LOAD_RECEIVE;
                    end
                end

                seq_pkg::LOAD_RECEIVE:
                begin
                    if (line_valid)
                    begin
                        line_count <= line_count + 1'b1;
                        if (last_line)
                        begin
                            // ready goes out the cycle after the final write
                            program_ready <= 1'b1;
                            state <= seq_pkg::LOAD_IDLE;
                        end
                    end
                end
            endcase
        end
    end

    // lines only come between start and the last line
    a_no_line_when_idle: assert property (@(posedge clk) disable iff (reset)
        state == seq_pkg::LOAD_IDLE |-> !line_valid);

endmodule

// File: src/program_memory.sv
`include "seq_consts.svh"

module program_memory
(
    input  logic            clk,
    input  logic            reset,
    input  logic            we,
    input  seq_pkg::pc_t    waddr,
    input  seq_pkg::line_t  wdata,
    input  logic            re,
    input  seq_pkg::pc_t    raddr,
    output seq_pkg::line_t  rdata,
    output logic            rvalid
);

    localparam int DEPTH = 1 << `LOG2_PROGRAM_SIZE;

    seq_pkg::line_t mem [DEPTH];

    always_ff @(posedge clk)
    begin
        if (we)
        begin
            mem[waddr[`LOG2_PROGRAM_SIZE-1:0]] <= wdata;
        end
        // registered read, one cycle latency
        if (re)
        begin
            rdata <= mem[raddr[`LOG2_PROGRAM_SIZE-1:0]];
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rvalid <= 1'b0;
        end
        else
        begin
            rvalid <= re;
        end
    end

endmodule

// File: sequencer/index_unit.sv
`include "seq_consts.svh"

module index_unit
(
    input  logic            clk,
    input  logic            reset,
    input  logic            clear,
    input  logic            advance,
    input  seq_pkg::word_t  step [3],
    input  seq_pkg::word_t  scale [3],
    input  seq_pkg::word_t  base,
    output seq_pkg::word_t  offset,
    output seq_pkg::word_t  idx [3]
);

    function automatic seq_pkg::word_t next_index(seq_pkg::word_t code, seq_pkg::word_t cur);
        seq_pkg::word_t result;
        case (code)
            `IDX_HOLD: result = cur;
            `IDX_INC:  result = cur + 1'b1;
            `IDX_DEC:  result = cur - 1'b1;
            default:
            begin
                // top bit set means relative step
                if (code[31])
                begin
                    result = cur + {1'b0, code[30:0]};
                end
                else
                begin
                    result = code;
                end
            end
        endcase
        return result;
    endfunction

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < 3; i++)
        begin
            if (reset || clear)
            begin
                idx[i] <= '0;
            end
            else if (advance)
            begin
                idx[i] <= next_index(step[i], idx[i]);
            end
        end
    end

    // strided offset in lines, wraps at 32 bits
    assign offset = base + idx[0] * scale[0] + idx[1] * scale[1] + idx[2] * scale[2];

endmodule

// File: sequencer/instr_sequencer.sv
`include "seq_consts.svh"

module instr_sequencer
(
    input  logic                clk,
    input  logic                reset,
    input  logic                program_ready,
    input  seq_pkg::line_t      rdata,
    input  logic                rvalid,
    input  logic [`NUM_OPS-1:0] op_done,
    output logic                re,
    output seq_pkg::pc_t        raddr,
    output logic [`NUM_OPS-1:0] op_start,
    output seq_pkg::word_t      op_offset,
    output seq_pkg::word_t      op_length,
    output logic                done
);

    seq_pkg::mach_state_t state;
    seq_pkg::pc_t pc;
    seq_pkg::pc_t next_pc;
    seq_pkg::line_t instr;
    seq_pkg::op_class_t op_class;
    seq_pkg::branch_t branch;
    logic nonblocking;
    logic [`NUM_OPS-1:0] class_bit;
    logic [`NUM_OPS-1:0] active;
    logic class_busy;
    logic may_continue;
    logic halt;
    logic idx_clear;
    logic idx_advance;
    seq_pkg::word_t idx [3];
    seq_pkg::word_t step [3];
    seq_pkg::word_t scale [3];
    seq_pkg::word_t offset;

    // true test takes low half of targets, false takes high half
    function automatic seq_pkg::pc_t branch_target(seq_pkg::word_t value,
        seq_pkg::word_t predicate, seq_pkg::word_t targets);
        logic taken;
        if (predicate[31:30] == 2'b01)
        begin
            taken = ~value[0];
        end
        else
        begin
            taken = (value == predicate);
        end
        return taken ? targets[15:0] : targets[31:16];
    endfunction

    // ====================
    // decode fields
    // ====================
    assign op_class = seq_pkg::op_class_t'(instr[15][7:4]);
    assign branch = seq_pkg::branch_t'(instr[15][3:0]);
    assign nonblocking = instr[15][8];

    always_comb
    begin
        for (int i = 0; i < `NUM_OPS; i++)
        begin
            class_bit[i] = (op_class == seq_pkg::op_class_t'(i + 1));
        end
        for (int i = 0; i < 3; i++)
        begin
            step[i] = instr[i];
            scale[i] = instr[10 + i];
        end
    end

    always_comb
    begin
        case (branch)
            seq_pkg::BR_ON_IDX0: next_pc = branch_target(idx[0], instr[13], instr[14]);
            seq_pkg::BR_ON_IDX1: next_pc = branch_target(idx[1], instr[13], instr[14]);
            seq_pkg::BR_ON_IDX2: next_pc = branch_target(idx[2], instr[13], instr[14]);
            default:             next_pc = pc + 1'b1;
        endcase
    end

    assign class_busy = |(class_bit & active);
    assign halt = (pc == `PC_HALT);
    assign may_continue = (|(class_bit & op_done)) || (op_class == seq_pkg::OP_NONE)
        || nonblocking;
    assign idx_clear = (state == seq_pkg::MACH_IDLE) && program_ready;
    assign idx_advance = (state == seq_pkg::MACH_EXECUTE) && !halt && may_continue;
    assign done = (state == seq_pkg::MACH_DONE);

    index_unit i_index_unit
    (
        .clk     (clk),
        .reset   (reset),
        .clear   (idx_clear),
        .advance (idx_advance),
        .step    (step),
        .scale   (scale),
        .base    (instr[3]),
        .offset  (offset),
        .idx     (idx)
    );

    // ====================
    // main FSM
    // ====================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= seq_pkg::MACH_IDLE;
            pc <= '0;
            re <= 1'b0;
            op_start <= '0;
        end
        else
        begin
            re <= 1'b0;
            op_start <= '0;
            case (state)
                seq_pkg::MACH_IDLE:
                begin
                    if (program_ready)
                    begin
                        pc <= '0;
                        re <= 1'b1;
                        raddr <= '0;
                        state <= seq_pkg::MACH_FETCH;
                    end
                end

                seq_pkg::MACH_FETCH:
                begin
                    if (rvalid)
                    begin
                        instr <= rdata;
                        state <= seq_pkg::MACH_DECODE;
                    end
                end

                seq_pkg::MACH_DECODE:
                begin
                    // hold until the class has no op in flight
                    if (!class_busy)
                    begin
                        op_start <= class_bit;
                        op_offset <= offset;
                        op_length <= instr[4];
                        pc <= next_pc;
                        state <= seq_pkg::MACH_EXECUTE;
                    end
                end

                seq_pkg::MACH_EXECUTE:
                begin
                    if (halt)
                    begin
                        state <= seq_pkg::MACH_DONE;
                    end
                    else if (may_continue)
                    begin
                        re <= 1'b1;
                        raddr <= pc;
                        state <= seq_pkg::MACH_FETCH;
                    end
                end

                seq_pkg::MACH_DONE:
                begin
                    pc <= '0;
                    state <= seq_pkg::MACH_IDLE;
                end

                default: state <= seq_pkg::MACH_IDLE;
            endcase
        end
    end

    // per-class in-flight tracking
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            active <= '0;
        end
        else
        begin
            for (int i = 0; i < `NUM_OPS; i++)
            begin
                if (op_done[i])
                begin
                    active[i] <= 1'b0;
                end
                else if (op_start[i])
                begin
                    active[i] <= 1'b1;
                end
            end
        end
    end

    // one class per start, and never a class still in flight
    a_start_onehot: assert property (@(posedge clk) disable iff (reset)
        $onehot0(op_start) && ((op_start & active) == '0));

    // units answer only for ops that were started
    a_done_when_active: assert property (@(posedge clk) disable iff (reset)
        (op_done & ~active) == '0);

endmodule

// File: src/glm_sequencer_top.sv
`include "seq_consts.svh"

module glm_sequencer_top
(
    input  logic                clk,
    input  logic                reset,
    input  logic                start,
    input  seq_pkg::pc_t        program_length,
    input  logic                line_valid,
    input  seq_pkg::line_t      line_data,
    input  logic [`NUM_OPS-1:0] op_done,
    output logic [`NUM_OPS-1:0] op_start,
    output seq_pkg::word_t      op_offset,
    output seq_pkg::word_t      op_length,
    output logic                done
);

    // loader to memory
    logic we;
    seq_pkg::pc_t waddr;
    seq_pkg::line_t wdata;
    logic program_ready;

    // sequencer fetch path
    logic re;
    seq_pkg::pc_t raddr;
    seq_pkg::line_t rdata;
    logic rvalid;

    program_loader i_program_loader
    (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .program_length (program_length),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .we             (we),
        .waddr          (waddr),
        .wdata          (wdata),
        .program_ready  (program_ready)
    );

    program_memory i_program_memory
    (
        .clk    (clk),
        .reset  (reset),
        .we     (we),
        .waddr  (waddr),
        .wdata  (wdata),
        .re     (re),
        .raddr  (raddr),
        .rdata  (rdata),
        .rvalid (rvalid)
    );

    instr_sequencer i_instr_sequencer
    (
        .clk           (clk),
        .reset         (reset),
        .program_ready (program_ready),
        .rdata         (rdata),
        .rvalid        (rvalid),
        .op_done       (op_done),
        .re            (re),
        .raddr         (raddr),
        .op_start      (op_start),
        .op_offset     (op_offset),
        .op_length     (op_length),
        .done          (done)
    );

endmodule

// File: tb/tb_glm_sequencer.sv
`include "seq_consts.svh"

module tb_glm_sequencer;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_CYCLES = 4000;
    localparam int DONE_LIMIT = 800;

    logic clk;
    logic reset;
    logic start;
    seq_pkg::pc_t program_length;
    logic line_valid;
    seq_pkg::line_t line_data;
    logic [`NUM_OPS-1:0] op_done;
    logic [`NUM_OPS-1:0] op_start;
    seq_pkg::word_t op_offset;
    seq_pkg::word_t op_length;
    logic done;

    // program under test and the dispatches it should produce
    seq_pkg::line_t program_lines[$];
    int exp_bit[$];
    seq_pkg::word_t exp_offset[$];
    seq_pkg::word_t exp_length[$];
    bit exp_blocking[$];
    int start_done_log[$];

    string test_name = "reset";
    int mismatch_count = 0;
    int other_errors = 0;
    int done_count = 0;
    int done_total = 0;
    int cycle_count = 0;
    int delay_floor = 1;
    int pending [`NUM_OPS];
    int started;
    bit running = 1'b0;
    bit blocking_open = 1'b0;
    int blocking_bit = 0;

    glm_sequencer_top i_glm_sequencer_top
    (
        .clk            (clk),
        .reset          (reset),
        .start          (start),
        .program_length (program_length),
        .line_valid     (line_valid),
        .line_data      (line_data),
        .op_done        (op_done),
        .op_start       (op_start),
        .op_offset      (op_offset),
        .op_length      (op_length),
        .done           (done)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count++;
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout after %0d cycles in %s", cycle_count, test_name);
            $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
            $display("Checks failed");
            $finish;
        end
    end

    task automatic check_value(string what, logic [31:0] expected, logic [31:0] actual);
        assert (expected === actual)
        else
        begin
            mismatch_count++;
            $display("mismatch %s %s: expected %0h, actual %0h", test_name, what, expected,
                actual);
        end
    endtask

    // ====================
    // operation unit model and dispatch scoreboard
    // ====================
    always @(negedge clk)
    begin
        if (reset)
        begin
            op_done = '0;
            for (int i = 0; i < `NUM_OPS; i++)
            begin
                pending[i] = 0;
            end
        end
        else
        begin
            started = -1;
            for (int i = 0; i < `NUM_OPS; i++)
            begin
                if (op_start[i])
                begin
                    started = i;
                end
            end
            if (started >= 0)
            begin
                assert (!blocking_open)
                else
                begin
                    other_errors++;
                    $display("%s: op_start while a blocking operation is still running",
                        test_name);
                end
                assert (pending[started] == 0)
                else
                begin
                    other_errors++;
                    $display("%s: op_start for a class that is still in flight", test_name);
                end
                if (exp_bit.size() == 0)
                begin
                    other_errors++;
                    $display("%s: op_start %b with no dispatch expected", test_name, op_start);
                end
                else
                begin
                    check_value("op_start", 1 << exp_bit[0], op_start);
                    check_value("op_offset", exp_offset[0], op_offset);
                    check_value("op_length", exp_length[0], op_length);
                    if (exp_blocking[0])
                    begin
                        blocking_open = 1'b1;
                        blocking_bit = started;
                    end
                    void'(exp_bit.pop_front());
                    void'(exp_offset.pop_front());
                    void'(exp_length.pop_front());
                    void'(exp_blocking.pop_front());
                end
                start_done_log.push_back(done_total);
            end

            // count down and answer
            op_done = '0;
            for (int i = 0; i < `NUM_OPS; i++)
            begin
                if (pending[i] != 0)
                begin
                    pending[i] = pending[i] - 1;
                    if (pending[i] == 0)
                    begin
                        op_done[i] = 1'b1;
                        done_total++;
                        if (blocking_open && blocking_bit == i)
                        begin
                            blocking_open = 1'b0;
                        end
                    end
                end
            end
            if (started >= 0)
            begin
                pending[started] = $urandom_range(6, delay_floor);
            end
            if (done)
            begin
                done_count++;
            end
        end
    end

    a_quiet_when_idle: assert property (@(posedge clk) disable iff (reset)
        !running |-> (op_start == '0 && !done && !i_glm_sequencer_top.re
            && !i_glm_sequencer_top.we))
    else
    begin
        other_errors++;
        $display("%s: DUT active while no program is running", test_name);
    end

    a_done_single: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else
    begin
        other_errors++;
        $display("%s: done held for more than one cycle", test_name);
    end

    // ====================
    // program building and running
    // ====================
    function automatic seq_pkg::line_t make_line(seq_pkg::op_class_t cls, seq_pkg::branch_t br,
        bit nonblocking, seq_pkg::word_t base, seq_pkg::word_t length);
        seq_pkg::line_t ln;
        ln = '0;
        ln[15] = {23'd0, nonblocking, cls, br};
        // both targets at halt unless a test changes them
        ln[14] = 32'hFFFF_FFFF;
        ln[3] = base;
        ln[4] = length;
        for (int i = 0; i < 3; i++)
        begin
            ln[i] = `IDX_HOLD;
        end
        return ln;
    endfunction

    task automatic expect_dispatch(seq_pkg::op_class_t cls, seq_pkg::word_t offset,
        seq_pkg::word_t length, bit blocking);
        exp_bit.push_back(int'(cls) - 1);
        exp_offset.push_back(offset);
        exp_length.push_back(length);
        exp_blocking.push_back(blocking);
    endtask

    task automatic load_program();
        @(negedge clk);
        running = 1'b1;
        start = 1'b1;
        program_length = seq_pkg::pc_t'(program_lines.size());
        @(negedge clk);
        start = 1'b0;
        foreach (program_lines[i])
        begin
            line_valid = 1'b1;
            line_data = program_lines[i];
            @(negedge clk);
        end
        line_valid = 1'b0;
    endtask

    task automatic wait_for_done();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!done && waited < DONE_LIMIT)
        begin
            @(negedge clk);
            waited++;
        end
        if (!done)
        begin
            other_errors++;
            $display("%s: no done pulse within %0d cycles", test_name, DONE_LIMIT);
        end
    endtask

    task automatic wait_units_idle();
        int waited;
        bit busy;
        waited = 0;
        busy = 1'b1;
        while (busy && waited < 20)
        begin
            busy = 1'b0;
            for (int i = 0; i < `NUM_OPS; i++)
            begin
                if (pending[i] != 0)
                begin
                    busy = 1'b1;
                end
            end
            @(negedge clk);
            waited++;
        end
    endtask

    task automatic run_program(string name);
        int done_before;
        done_before = done_count;
        test_name = name;
        done_total = 0;
        start_done_log.delete();
        load_program();
        wait_for_done();
        @(negedge clk);
        running = 1'b0;
        wait_units_idle();
        check_value("done pulses", done_before + 1, done_count);
        check_value("dispatches left", 0, exp_bit.size());
        exp_bit.delete();
        exp_offset.delete();
        exp_length.delete();
        exp_blocking.delete();
        program_lines.delete();
    endtask

    // ====================
    // tests
    // ====================
    initial
    begin
        seq_pkg::line_t ln;
        reset = 1'b1;
        start = 1'b0;
        program_length = '0;
        line_valid = 1'b0;
        line_data = '0;
        op_done = '0;
        void'($urandom(32'hf617));
        repeat (8) @(negedge clk);
        reset = 1'b0;

        test_name = "idle_after_reset";
        repeat (20) @(negedge clk);
        check_value("done pulses", 0, done_count);

        // class none only, last line branches to halt either way
        program_lines.push_back(make_line(seq_pkg::OP_NONE, seq_pkg::BR_NEXT, 0, 0, 0));
        program_lines.push_back(make_line(seq_pkg::OP_NONE, seq_pkg::BR_NEXT, 0, 0, 0));
        program_lines.push_back(make_line(seq_pkg::OP_NONE, seq_pkg::BR_ON_IDX0, 0, 0, 0));
        run_program("straight_line");

        // indexes loaded directly to 3, 5, 7 before the load
        ln = make_line(seq_pkg::OP_NONE, seq_pkg::BR_NEXT, 0, 0, 0);
        ln[0] = 3;
        ln[1] = 5;
        ln[2] = 7;
        program_lines.push_back(ln);
        ln = make_line(seq_pkg::OP_LOAD, seq_pkg::BR_NEXT, 0, 32'h100, 32'h40);
        ln[10] = 4;
        ln[11] = 16;
        ln[12] = 64;
        program_lines.push_back(ln);
        expect_dispatch(seq_pkg::OP_LOAD, 32'h100 + 3 * 4 + 5 * 16 + 7 * 64, 32'h40, 1);
        program_lines.push_back(make_line(seq_pkg::OP_WRITEBACK, seq_pkg::BR_ON_IDX0, 1,
            32'h20, 8));
        expect_dispatch(seq_pkg::OP_WRITEBACK, 32'h20, 8, 0);
        run_program("dispatch_values");

        // loops on itself until idx0 equals 4
        ln = make_line(seq_pkg::OP_WRITEBACK, seq_pkg::BR_ON_IDX0, 0, 32'h1000, 32'h80);
        ln[0] = `IDX_INC;
        ln[10] = 32'h10;
        ln[13] = 4;
        ln[14] = 32'h0000_0001;
        program_lines.push_back(ln);
        program_lines.push_back(make_line(seq_pkg::OP_NONE, seq_pkg::BR_ON_IDX0, 0, 0, 0));
        for (int i = 0; i <= 4; i++)
        begin
            expect_dispatch(seq_pkg::OP_WRITEBACK, 32'h1000 + i * 32'h10, 32'h80, 1);
        end
        run_program("counted_loop");

        // even goes to line 1, odd to line 2
        ln = make_line(seq_pkg::OP_NONE, seq_pkg::BR_ON_IDX0, 0, 0, 0);
        ln[0] = `IDX_INC;
        ln[13] = 32'h4000_0000;
        ln[14] = 32'h0002_0001;
        program_lines.push_back(ln);
        ln = make_line(seq_pkg::OP_PREFETCH, seq_pkg::BR_ON_IDX0, 1, 32'h200, 16);
        ln[13] = 4;
        ln[14] = 32'h0000_FFFF;
        program_lines.push_back(ln);
        ln = make_line(seq_pkg::OP_DOT, seq_pkg::BR_ON_IDX0, 1, 32'h300, 24);
        ln[13] = 4;
        ln[14] = 32'h0000_FFFF;
        program_lines.push_back(ln);
        for (int i = 0; i < 4; i++)
        begin
            if (i % 2 == 0)
            begin
                expect_dispatch(seq_pkg::OP_PREFETCH, 32'h200, 16, 0);
            end
            else
            begin
                expect_dispatch(seq_pkg::OP_DOT, 32'h300, 24, 0);
            end
        end
        run_program("even_branch");

        // slow units so copy and load overlap
        delay_floor = 5;
        program_lines.push_back(make_line(seq_pkg::OP_COPY, seq_pkg::BR_NEXT, 1, 32'h500, 4));
        expect_dispatch(seq_pkg::OP_COPY, 32'h500, 4, 0);
        program_lines.push_back(make_line(seq_pkg::OP_LOAD, seq_pkg::BR_NEXT, 1, 32'h400, 4));
        expect_dispatch(seq_pkg::OP_LOAD, 32'h400, 4, 0);
        program_lines.push_back(make_line(seq_pkg::OP_LOAD, seq_pkg::BR_ON_IDX0, 1,
            32'h600, 4));
        expect_dispatch(seq_pkg::OP_LOAD, 32'h600, 4, 0);
        run_program("overlap");
        check_value("starts logged", 3, start_done_log.size());
        if (start_done_log.size() >= 2)
        begin
            check_value("op_done before second start", 0, start_done_log[1]);
        end
        delay_floor = 1;

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, other_errors);
        if (mismatch_count == 0 && other_errors == 0)
        begin
            $display("All checks passed");
        end
        else
        begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: flist.f
+incdir+common
common/seq_pkg.sv
loader/program_loader.sv
src/program_memory.sv
sequencer/index_unit.sv
sequencer/instr_sequencer.sv
src/glm_sequencer_top.sv
tb/tb_glm_sequencer.sv

// File: Bender.yml
package:
  name: glm_sequencer

sources:
  - include_dirs:
      - common
    files:
      - common/seq_pkg.sv
      - loader/program_loader.sv
      - src/program_memory.sv
      - sequencer/index_unit.sv
      - sequencer/instr_sequencer.sv
      - src/glm_sequencer_top.sv
  - target: test
    include_dirs:
      - common
    files:
      - tb/tb_glm_sequencer.sv
